// ==== hdl/colmix_pkg.sv ====
// shared widths, layer codes and priority index layout, imported by every colour mixer RTL file
package colmix_pkg;

    localparam int char_w  = 7;   // char layer pixel
    localparam int obj_w   = 8;   // sprite layer pixel
    localparam int scr_w   = 8;   // scroll layer pixel
    localparam int pal_aw  = 9;   // entries per palette bank
    localparam int cpu_aw  = 10;  // msb selects the blue bank
    localparam int prio_aw = 8;   // 256 entry priority prom
    localparam int rgb_w   = 4;   // per colour component
    localparam int cpu_dw  = 8;   // cpu data bus, same as a green/red entry

    // priority prom output
    // both low codes mean char
    typedef enum logic [1:0] {
        layer_char     = 2'd0,
        layer_char_alt = 2'd1,
        layer_obj      = 2'd2,
        layer_scr      = 2'd3
    } layer_t;

    // bit positions inside the prom index
    localparam int idx_scr_msb    = 7;  // scroll pixel bit 7
    localparam int idx_obj_msb    = 6;  // obj pixel bit 7
    localparam int idx_obj_blank  = 5;  // obj low nibble all zero
    localparam int idx_char_blank = 4;  // char low nibble all zero
                                        // bits 3..0 take the scroll low nibble

    // top two palette address bits per winning layer
    function automatic logic [1:0] pal_index_base(input layer_t code);
        case (code)
            layer_obj: return 2'b01;
            layer_scr: return 2'b10;
            default:   return 2'b00;    // char, either code
        endcase
    endfunction

    function automatic logic [prio_aw-1:0] prio_index(
        input logic [char_w-1:0] char_pxl,
        input logic [obj_w-1:0]  obj_pxl,
        input logic [scr_w-1:0]  scr_pxl
    );
        logic [prio_aw-1:0] idx;
        idx                 = '0;
        idx[3:0]            = scr_pxl[3:0];
        idx[idx_char_blank] = ~|char_pxl[3:0];
        idx[idx_obj_blank]  = ~|obj_pxl[3:0];
        idx[idx_obj_msb]    = obj_pxl[obj_w-1];
        idx[idx_scr_msb]    = scr_pxl[scr_w-1];
        return idx;
    endfunction

endpackage

// ==== hdl/pal_bus_if.sv ====
// cpu palette access bundle, driven by the cpu port and served by the palette lookup
interface pal_bus_if
    import colmix_pkg::*;
();

    logic              cs;        // cpu owns the palette address this cycle
    logic [pal_aw-1:0] addr;      // entry address, bank bit stripped
    logic [cpu_dw-1:0] wdata;
    logic              we_gr;     // one clock pulse per write strobe
    logic              we_b;
    logic [cpu_dw-1:0] rdata_gr;  // registered ram output
    logic [rgb_w-1:0]  rdata_b;

    // cpu side
    modport port (
        output cs,
        output addr,
        output wdata,
        output we_gr,
        output we_b,
        input  rdata_gr,
        input  rdata_b
    );

    // ram side
    modport lookup (
        input  cs,
        input  addr,
        input  wdata,
        input  we_gr,
        input  we_b,
        output rdata_gr,
        output rdata_b
    );

endinterface

// ==== hdl/prio_select.sv ====
// priority prom with load port, picks the winning layer and forms the pixel palette address
module prio_select
    import colmix_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [char_w-1:0]  char_pxl,
    input  logic [obj_w-1:0]   obj_pxl,
    input  logic [scr_w-1:0]   scr_pxl,
    input  logic [prio_aw-1:0] prog_addr,
    input  logic [1:0]         prom_din,
    input  logic               prom_we,
    output logic [pal_aw-1:0]  pix_addr   // one clock after the code
);

    localparam int pxl_keep = pal_aw - 2;  // pixel bits under the layer base

    layer_t              prom [2**prio_aw];
    layer_t              prio_code;
    logic [prio_aw-1:0]  prio_idx;
    logic [char_w-1:0]   char_d;
    logic [obj_w-1:0]    obj_d;
    logic [scr_w-1:0]    scr_d;
    logic [pxl_keep-1:0] win_pxl;

    assign prio_idx = prio_index(char_pxl, obj_pxl, scr_pxl);

    // load port, read sees the write from the next clock
    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom[prog_addr] <= layer_t'(prom_din);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_code <= layer_char;
        end else begin
            prio_code <= prom[prio_idx];   // synchronous prom read
        end
    end

    // pixels follow the prom by one clock so each code meets its own pixel
    always_ff @(posedge clk) begin
        char_d <= char_pxl;
        obj_d  <= obj_pxl;
        scr_d  <= scr_pxl;
    end

    always_comb begin
        case (prio_code)
            layer_obj: win_pxl = obj_d[pxl_keep-1:0];   // bit 7 dropped
            layer_scr: win_pxl = scr_d[pxl_keep-1:0];
            default:   win_pxl = char_d[pxl_keep-1:0];
        endcase
    end

    always_ff @(posedge clk) begin
        pix_addr <= {pal_index_base(prio_code), win_pxl};
    end

    // programmed prom must resolve every index the layers can form
    a_code_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({char_pxl, obj_pxl, scr_pxl}) |=> !$isunknown(prio_code))
        else $error("priority code unknown for known layer pixels");

endmodule

// ==== hdl/cpu_pal_port.sv ====
// cpu side of the palette that turns chip select into bank write pulses, instanced by the top
module cpu_pal_port
    import colmix_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              pal_cs,
    input  logic              cpu_wr,
    input  logic [cpu_aw-1:0] cpu_addr,
    input  logic [cpu_dw-1:0] cpu_din,
    output logic [cpu_dw-1:0] pal_dout,   // valid 3 clocks after pal_cs rises
    pal_bus_if.port           bus
);

    logic bank_b;      // upper half of the cpu map is blue
    logic cs_d;
    logic wr_strobe;

    assign bank_b    = cpu_addr[cpu_aw-1];
    assign wr_strobe = pal_cs && !cs_d && cpu_wr;   // first clock of a write only

    // address and data are held by the cpu for the whole access
    assign bus.cs    = pal_cs;
    assign bus.addr  = cpu_addr[pal_aw-1:0];
    assign bus.wdata = cpu_din;

    always_ff @(posedge clk) begin
        if (reset) begin
            cs_d      <= 1'b0;
            bus.we_gr <= 1'b0;
            bus.we_b  <= 1'b0;
            pal_dout  <= '0;
        end else begin
            cs_d      <= pal_cs;
            bus.we_gr <= wr_strobe && !bank_b;   // ram writes on the next edge
            bus.we_b  <= wr_strobe && bank_b;
            if (pal_cs) begin
                // blue entries read back in the low nibble
                pal_dout <= bank_b ? {{(cpu_dw - rgb_w){1'b0}}, bus.rdata_b}
                                   : bus.rdata_gr;
            end
        end
    end

    // write lands one clock after the strobe, so the access must not move
    a_cpu_hold: assert property (@(posedge clk) disable iff (reset)
        pal_cs && cs_d |-> $stable({cpu_addr, cpu_din, cpu_wr}))
        else $error("cpu access changed while pal_cs held");

endmodule

// ==== hdl/palette_lookup.sv ====
// palette rams shared by cpu and pixel path, applies blanking and registers rgb on pxl_cen
module palette_lookup
    import colmix_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              pxl_cen,
    input  logic [pal_aw-1:0] pix_addr,
    input  logic              vbl,
    input  logic              hbl,
    pal_bus_if.lookup         bus,
    output logic [rgb_w-1:0]  red,
    output logic [rgb_w-1:0]  green,
    output logic [rgb_w-1:0]  blue,
    output logic              lvbl_dly,   // low while blanking
    output logic              lhbl_dly
);

    // sampled with the pixels, then three clocks to meet the ram data
    localparam int bl_stages = 4;

    logic [cpu_dw-1:0]    pal_gr [2**pal_aw];   // green high nibble, red low
    logic [rgb_w-1:0]     pal_b  [2**pal_aw];
    logic [pal_aw-1:0]    pal_addr;
    logic [cpu_dw-1:0]    gr_q;
    logic [rgb_w-1:0]     b_q;
    logic [bl_stages-1:0] vbl_sr;
    logic [bl_stages-1:0] hbl_sr;
    logic                 blank;

    // cpu wins the address, pixels show whatever it selects
    always_ff @(posedge clk) begin
        pal_addr <= bus.cs ? bus.addr : pix_addr;
    end

    always_ff @(posedge clk) begin
        if (bus.we_gr) begin
            pal_gr[pal_addr] <= bus.wdata;
        end
        gr_q <= pal_gr[pal_addr];   // old data on the write edge
    end

    always_ff @(posedge clk) begin
        if (bus.we_b) begin
            pal_b[pal_addr] <= bus.wdata[rgb_w-1:0];
        end
        b_q <= pal_b[pal_addr];
    end

    assign bus.rdata_gr = gr_q;
    assign bus.rdata_b  = b_q;

    // blanking delay line, runs every clk like the address path
    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_sr <= '1;   // start out blanked
            hbl_sr <= '1;
        end else begin
            vbl_sr <= {vbl_sr[bl_stages-2:0], vbl};
            hbl_sr <= {hbl_sr[bl_stages-2:0], hbl};
        end
    end

    assign blank = vbl_sr[bl_stages-1] || hbl_sr[bl_stages-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            lvbl_dly <= 1'b0;
            lhbl_dly <= 1'b0;
        end else if (pxl_cen) begin
            if (blank) begin
                red   <= '0;   // black in both blanking periods
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= gr_q[rgb_w-1:0];
                green <= gr_q[2*rgb_w-1:rgb_w];
                blue  <= b_q;
            end
            lvbl_dly <= !vbl_sr[bl_stages-1];
            lhbl_dly <= !hbl_sr[bl_stages-1];
        end
    end

    // write pulse lands while the cpu still owns the address
    a_we_in_cs: assert property (@(posedge clk) disable iff (reset)
        (bus.we_gr || bus.we_b) |-> bus.cs)
        else $error("palette write outside a cpu access");

endmodule

// ==== hdl/colmix_top.sv ====
// colour mixer top level, plain board ports wired to priority, cpu port and palette blocks
module colmix_top
    import colmix_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    // cpu palette access
    input  logic [cpu_dw-1:0]  cpu_din,
    input  logic [cpu_aw-1:0]  cpu_addr,
    input  logic               pal_cs,
    input  logic               cpu_wr,
    output logic [cpu_dw-1:0]  pal_dout,
    // blanking
    input  logic               vbl,
    input  logic               hbl,
    output logic               lvbl_dly,
    output logic               lhbl_dly,
    // layer pixels
    input  logic [char_w-1:0]  char_pxl,
    input  logic [obj_w-1:0]   obj_pxl,
    input  logic [scr_w-1:0]   scr_pxl,
    // priority prom loader
    input  logic [prio_aw-1:0] prog_addr,
    input  logic [1:0]         prom_din,
    input  logic               prom_we,
    // video out
    output logic [rgb_w-1:0]   red,
    output logic [rgb_w-1:0]   green,
    output logic [rgb_w-1:0]   blue
);

    logic [pal_aw-1:0] pix_addr;

    pal_bus_if u_pal_bus ();

    prio_select u_prio_select (
        .clk       (clk),
        .reset     (reset),
        .char_pxl  (char_pxl),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .prog_addr (prog_addr),
        .prom_din  (prom_din),
        .prom_we   (prom_we),
        .pix_addr  (pix_addr)
    );

    cpu_pal_port u_cpu_pal_port (
        .clk      (clk),
        .reset    (reset),
        .pal_cs   (pal_cs),
        .cpu_wr   (cpu_wr),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .pal_dout (pal_dout),
        .bus      (u_pal_bus.port)
    );

    palette_lookup u_palette_lookup (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .pix_addr (pix_addr),
        .vbl      (vbl),
        .hbl      (hbl),
        .bus      (u_pal_bus.lookup),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lvbl_dly (lvbl_dly),
        .lhbl_dly (lhbl_dly)
    );

endmodule

// ==== verification/colmix_checker.sv ====
// checker instanced next to the DUT that mirrors prom and palette writes and predicts outputs
module colmix_checker
    import colmix_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  logic [cpu_dw-1:0]  cpu_din,
    input  logic [cpu_aw-1:0]  cpu_addr,
    input  logic               pal_cs, cpu_wr,
    input  logic [cpu_dw-1:0]  pal_dout,
    input  logic               vbl, hbl, lvbl_dly, lhbl_dly,
    input  logic [char_w-1:0]  char_pxl,
    input  logic [obj_w-1:0]   obj_pxl,
    input  logic [scr_w-1:0]   scr_pxl,
    input  logic [prio_aw-1:0] prog_addr,
    input  logic [1:0]         prom_din,
    input  logic               prom_we,
    input  logic [rgb_w-1:0]   red, green, blue,
    output int                 error_count,
    output int                 check_count
);

    logic [1:0] prom_m [256];
    logic [7:0] gr_m [512];      // green in the high nibble and red in the low
    logic [3:0] b_m [512];
    logic [8:0] h_addr [4];      // [3] is the pixel from four clocks back
    logic [3:0] h_vbl, h_hbl, h_cs;
    logic [3:0] exp_r, exp_g, exp_b;
    logic [7:0] exp_dout;
    logic       exp_lvbl, exp_lhbl;
    logic       rgb_known, dout_chk, cs_prev, cpu_seen;
    logic       active = 1'b0;   // compares start at the first clock edge
    int         cs_cnt;
    int         errors = 0;
    int         checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // layer base 00 char 01 obj 10 scroll over the low 7 pixel bits of the prom winner
    function automatic logic [8:0] pixel_address(input logic [6:0] c, input logic [7:0] o,
                                                 input logic [7:0] s);
        logic [7:0] idx;
        idx = {s[7], o[7], o[3:0] == 4'h0, c[3:0] == 4'h0, s[3:0]};
        case (prom_m[idx])
            2'd2:    return {2'b01, o[6:0]};
            2'd3:    return {2'b10, s[6:0]};
            default: return {2'b00, c[6:0]};   // codes 0 and 1
        endcase
    endfunction

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] expct);
        checks++;
        if (got !== expct) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, expct);
        end
    endtask

    always @(posedge clk) begin
        active = 1'b1;
        if (reset) begin
            h_vbl     = 4'hf;   // reset starts out blanked
            h_hbl     = 4'hf;
            h_cs      = 4'h0;
            exp_r     = 4'h0;
            exp_g     = 4'h0;
            exp_b     = 4'h0;
            exp_lvbl  = 1'b0;
            exp_lhbl  = 1'b0;
            exp_dout  = 8'h00;
            rgb_known = 1'b1;
            cpu_seen  = 1'b0;
            cs_prev   = 1'b0;
            cs_cnt    = 0;
        end else begin
            if (pxl_cen) begin
                exp_lvbl  = !h_vbl[3];
                exp_lhbl  = !h_hbl[3];
                rgb_known = 1'b1;
                if (h_vbl[3] || h_hbl[3]) begin
                    {exp_g, exp_r} = 8'h00;
                    exp_b          = 4'h0;
                end else if (|h_cs) begin
                    rgb_known = 1'b0;   // ram saw the cpu address
                end else begin
                    {exp_g, exp_r} = gr_m[h_addr[3]];
                    exp_b          = b_m[h_addr[3]];
                end
            end
            h_vbl = {h_vbl[2:0], vbl};
            h_hbl = {h_hbl[2:0], hbl};
            h_cs  = {h_cs[2:0], pal_cs};
            if (pal_cs && !cs_prev) begin
                cs_cnt   = 1;
                cpu_seen = 1'b1;
                if (cpu_wr && cpu_addr[9]) begin
                    b_m[cpu_addr[8:0]] = cpu_din[3:0];
                end else if (cpu_wr) begin
                    gr_m[cpu_addr[8:0]] = cpu_din;
                end
                exp_dout = cpu_addr[9] ? {4'h0, b_m[cpu_addr[8:0]]} : gr_m[cpu_addr[8:0]];
            end else if (pal_cs) begin
                cs_cnt++;
            end else begin
                cs_cnt = 0;
            end
            cs_prev = pal_cs;
        end
        // reads valid from the third clock of the access and zero before any access
        dout_chk  = !cpu_seen || (pal_cs && !cpu_wr && cs_cnt >= 3);
        h_addr[3] = h_addr[2];
        h_addr[2] = h_addr[1];
        h_addr[1] = h_addr[0];
        h_addr[0] = pixel_address(char_pxl, obj_pxl, scr_pxl);
        if (prom_we) begin
            prom_m[prog_addr] = prom_din;   // seen by reads from the next clock
        end
    end

    // outputs settle at posedge and are compared half a clock later
    always @(negedge clk) begin
        if (active) begin
            if (rgb_known) begin
                compare("red", {4'h0, red}, {4'h0, exp_r});
                compare("green", {4'h0, green}, {4'h0, exp_g});
                compare("blue", {4'h0, blue}, {4'h0, exp_b});
            end
            compare("lvbl_dly", {7'h0, lvbl_dly}, {7'h0, exp_lvbl});
            compare("lhbl_dly", {7'h0, lhbl_dly}, {7'h0, exp_lhbl});
            if (dout_chk) begin
                compare("pal_dout", pal_dout, exp_dout);
            end
        end
    end

endmodule

// ==== verification/colmix_tb.sv ====
// colour mixer testbench top that loads prom and palette and steps a stimulus table through the DUT
module colmix_tb;

    localparam int n_steps    = 25;
    localparam int max_cycles = 20000;   // palette fill dominates the run

    localparam logic [1:0] op_pix = 2'd0;   // one pixel clock
    localparam logic [1:0] op_wr  = 2'd1;   // cpu palette write
    localparam logic [1:0] op_rd  = 2'd2;   // cpu palette read

    typedef struct packed {
        logic [2:0] test;
        logic [1:0] op;
        logic [6:0] chr;
        logic [7:0] obj;
        logic [7:0] scr;
        logic       vbl;
        logic       hbl;
        logic       cen;
        logic [9:0] addr;   // cpu rows only
        logic [7:0] data;
    } step_t;

    logic        clk;
    logic        reset;
    logic        pxl_cen;
    logic [7:0]  cpu_din;
    logic [9:0]  cpu_addr;
    logic        pal_cs;
    logic        cpu_wr;
    logic [7:0]  pal_dout;
    logic        vbl, hbl, lvbl_dly, lhbl_dly;
    logic [6:0]  char_pxl;
    logic [7:0]  obj_pxl, scr_pxl;
    logic [7:0]  prog_addr;
    logic [1:0]  prom_din;
    logic        prom_we;
    logic [3:0]  red, green, blue;
    int          error_count, check_count;
    int          err_start, chk_start, tests_failed, cur_test;
    logic [31:0] rng;
    logic [1:0]  prom_img [256];
    step_t       steps [n_steps];
    string       test_name [1:6];

    colmix_top u_colmix_top (.*);

    colmix_checker u_checker (.*);

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // cs held four clocks and released for one so the next access is a fresh strobe
    task automatic cpu_access(input logic [9:0] addr, input logic [7:0] data, input logic wr);
        pal_cs   = 1'b1;
        cpu_addr = addr;
        cpu_din  = data;
        cpu_wr   = wr;
        repeat (4) @(negedge clk);
        pal_cs = 1'b0;
        cpu_wr = 1'b0;
        @(negedge clk);
    endtask

    // drains the pipeline and reports the test from the checker counts
    task automatic finish_test(input int num);
        int errs;
        int chks;
        pxl_cen = 1'b1;
        repeat (5) @(negedge clk);     // pixel latency plus one
        @(posedge clk);                // counts are stable between compares
        errs      = error_count - err_start;
        chks      = check_count - chk_start;
        err_start = error_count;
        chk_start = check_count;
        if (errs == 0) begin
            $display("test %0d %s: pass, %0d checks", num, test_name[num], chks);
        end else begin
            $display("test %0d %s: fail, %0d of %0d checks wrong",
                     num, test_name[num], errs, chks);
            tests_failed++;
        end
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    initial begin
        for (int cyc = 0; cyc < max_cycles; cyc++) begin
            @(posedge clk);
        end
        $display("timeout: run still going after %0d clocks", max_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        test_name[1] = "reset state";
        test_name[2] = "cpu write and readback";
        test_name[3] = "priority selection";
        test_name[4] = "blank layers";
        test_name[5] = "blanking";
        test_name[6] = "pxl_cen gating";
        //          test  op      char   obj    scr    vbl   hbl   cen   addr     data
        steps[0]  = '{3'd2, op_wr,  7'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 10'h005, 8'ha7};
        steps[1]  = '{3'd2, op_wr,  7'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 10'h205, 8'h3c};
        steps[2]  = '{3'd2, op_rd,  7'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 10'h005, 8'h00};
        steps[3]  = '{3'd2, op_rd,  7'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 10'h205, 8'h00};
        steps[4]  = '{3'd2, op_rd,  7'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 10'h1ff, 8'h00};
        steps[5]  = '{3'd2, op_rd,  7'h00, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 10'h2c3, 8'h00};
        steps[6]  = '{3'd3, op_pix, 7'h15, 8'h23, 8'h47, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[7]  = '{3'd3, op_pix, 7'h6b, 8'h9e, 8'h8d, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[8]  = '{3'd3, op_pix, 7'h01, 8'hf7, 8'h02, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[9]  = '{3'd3, op_pix, 7'h7f, 8'h41, 8'hc9, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[10] = '{3'd3, op_pix, 7'h32, 8'h85, 8'hb6, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[11] = '{3'd4, op_pix, 7'h30, 8'h27, 8'h13, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[12] = '{3'd4, op_pix, 7'h2e, 8'h90, 8'h84, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[13] = '{3'd4, op_pix, 7'h50, 8'h60, 8'hf0, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[14] = '{3'd5, op_pix, 7'h15, 8'h23, 8'h47, 1'b1, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[15] = '{3'd5, op_pix, 7'h6b, 8'h9e, 8'h8d, 1'b0, 1'b1, 1'b1, 10'h000, 8'h00};
        steps[16] = '{3'd5, op_pix, 7'h01, 8'hf7, 8'h02, 1'b1, 1'b1, 1'b1, 10'h000, 8'h00};
        steps[17] = '{3'd5, op_pix, 7'h7f, 8'h41, 8'hc9, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        // four new pixels fill the pipe so the held colour differs from the ram data
        steps[18] = '{3'd6, op_pix, 7'h32, 8'h85, 8'hb6, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[19] = '{3'd6, op_pix, 7'h49, 8'h1c, 8'h5a, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[20] = '{3'd6, op_pix, 7'h0a, 8'h77, 8'he5, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[21] = '{3'd6, op_pix, 7'h3d, 8'hc2, 8'h39, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};
        steps[22] = '{3'd6, op_pix, 7'h26, 8'h5b, 8'h71, 1'b0, 1'b0, 1'b0, 10'h000, 8'h00};
        steps[23] = '{3'd6, op_pix, 7'h5c, 8'he3, 8'ha8, 1'b0, 1'b0, 1'b0, 10'h000, 8'h00};
        steps[24] = '{3'd6, op_pix, 7'h11, 8'h39, 8'hd4, 1'b0, 1'b0, 1'b1, 10'h000, 8'h00};

        reset    = 1'b1;
        pxl_cen  = 1'b1;
        cpu_din  = 8'h00;
        cpu_addr = 10'h000;
        pal_cs   = 1'b0;
        cpu_wr   = 1'b0;
        vbl      = 1'b1;   // blanked until the palette is filled
        hbl      = 1'b1;
        char_pxl = 7'h00;
        obj_pxl  = 8'h00;
        scr_pxl  = 8'h00;
        rng      = 32'd37;
        for (int i = 0; i < 256; i++) begin
            rng         = next_random(rng);
            prom_img[i] = rng[1:0];
        end
        // all-zero pixels index entry 0x30 so it is loaded under reset
        prog_addr = 8'h30;
        prom_din  = prom_img[8'h30];
        prom_we   = 1'b1;
        @(negedge clk);
        prom_we = 1'b0;
        repeat (9) @(negedge clk);
        reset        = 1'b0;
        err_start    = 0;
        chk_start    = 0;
        tests_failed = 0;

        prom_we = 1'b1;
        for (int i = 0; i < 256; i++) begin
            prog_addr = i[7:0];
            prom_din  = prom_img[i];
            @(negedge clk);
        end
        prom_we = 1'b0;
        finish_test(1);

        // fills both banks with blue from 0x200 up
        for (int i = 0; i < 1024; i++) begin
            rng = next_random(rng);
            cpu_access(i[9:0], rng[7:0], 1'b1);
        end
        cur_test = 2;
        for (int s = 0; s < n_steps; s++) begin
            if (int'(steps[s].test) != cur_test) begin
                finish_test(cur_test);
                cur_test = int'(steps[s].test);
            end
            char_pxl = steps[s].chr;
            obj_pxl  = steps[s].obj;
            scr_pxl  = steps[s].scr;
            vbl      = steps[s].vbl;
            hbl      = steps[s].hbl;
            pxl_cen  = steps[s].cen;
            if (steps[s].op == op_pix) begin
                @(negedge clk);
            end else begin
                cpu_access(steps[s].addr, steps[s].data, steps[s].op == op_wr);
            end
        end
        finish_test(cur_test);

        $display("6 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, chk_start, err_start);
        if (tests_failed == 0 && err_start == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/colmix_pkg.sv
hdl/pal_bus_if.sv
hdl/prio_select.sv
hdl/cpu_pal_port.sv
hdl/palette_lookup.sv
hdl/colmix_top.sv
verification/colmix_checker.sv
verification/colmix_tb.sv

// ==== Makefile ====
# Verilator build and run of the colour mixer testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := colmix_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
